//--- pip_pkg.sv
`default_nettype none

package pip_pkg;

  localparam int XLEN   = 32;
  localparam int REG_AW = 5;
  localparam int BE_W   = XLEN / 8;

  localparam logic [XLEN-1:0] RESET_PC = '0;

  // MIPS major opcodes
  localparam logic [5:0] OPC_RTYPE = 6'h00;
  localparam logic [5:0] OPC_ADDI  = 6'h08;
  localparam logic [5:0] OPC_LW    = 6'h23;
  localparam logic [5:0] OPC_SW    = 6'h2b;

  // R-type function field
  localparam logic [5:0] FN_ADD = 6'h20;
  localparam logic [5:0] FN_SUB = 6'h22;
  localparam logic [5:0] FN_AND = 6'h24;
  localparam logic [5:0] FN_OR  = 6'h25;
  localparam logic [5:0] FN_SLT = 6'h2a;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT
  } alu_op_t;

  typedef enum logic [1:0] {
    FWD_NONE,
    FWD_EX_MEM,
    FWD_MEM_WB
  } fwd_t;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] instr;
  } if_id_t;

  typedef struct packed {
    logic              valid;
    logic [XLEN-1:0]   a_val;
    logic [XLEN-1:0]   b_val;
    logic [REG_AW-1:0] a_reg;
    logic [REG_AW-1:0] b_reg;
    logic [XLEN-1:0]   imm;
    logic              use_imm;
    alu_op_t           alu_op;
    logic              load;
    logic              store;
    logic [REG_AW-1:0] dest;
    logic              dest_valid;
  } id_ex_t;

  typedef struct packed {
    logic              valid;
    logic [XLEN-1:0]   result;
    logic [XLEN-1:0]   store_data;
    logic              load;
    logic              store;
    logic [REG_AW-1:0] dest;
    logic              dest_valid;
  } ex_mem_t;

  typedef struct packed {
    logic              valid;
    logic [XLEN-1:0]   result;
    logic [REG_AW-1:0] dest;
    logic              dest_valid;
  } mem_wb_t;

endpackage

`default_nettype wire

//--- pip_stage_reg.sv
`timescale 1ns/1ps
`default_nettype none

module pip_stage_reg #(
  parameter type payload_t = logic
) (
  input  wire logic clock_i,
  input  wire logic rst_n_i,
  input  wire logic hold_i,
  input  wire logic bubble_i,
  input  payload_t  d_i,
  output payload_t  q_o
);

  always_ff @(posedge clock_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      q_o <= payload_t'('0);
    end else if (hold_i) begin
      q_o <= q_o;
    end else if (bubble_i) begin
      // All-zero payload is a bubble
      q_o <= payload_t'('0);
    end else begin
      q_o <= d_i;
    end
  end

endmodule

`default_nettype wire

//--- pip_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module pip_fetch import pip_pkg::*; (
  input  wire logic            clock_i,
  input  wire logic            rst_n_i,
  input  wire logic            stall_i,
  output logic      [XLEN-1:0] icache_addr_o,
  output logic                 icache_rd_o,
  input  wire logic [XLEN-1:0] icache_data_i,
  input  wire logic            icache_waitrequest_i,
  output if_id_t               out_o
);

  logic [XLEN-1:0] pc_q;
  logic            pend_q;
  logic            held_q;
  logic [XLEN-1:0] held_word_q;
  logic            accept;

  // A request left waiting is kept up until the cache takes it
  assign icache_rd_o   = (~stall_i & ~held_q) | pend_q;
  assign icache_addr_o = pc_q;
  assign accept        = icache_rd_o & ~icache_waitrequest_i;

  // Word taken during a stall is parked until decode can take it
  assign out_o.valid = held_q | accept;
  assign out_o.instr = held_q ? held_word_q : icache_data_i;

  always_ff @(posedge clock_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q   <= RESET_PC;
      pend_q <= 1'b0;
      held_q <= 1'b0;
    end else begin
      pend_q <= icache_rd_o & icache_waitrequest_i;
      held_q <= stall_i & (held_q | accept);
      if (accept) begin
        pc_q <= pc_q + XLEN'(4);
      end
    end
  end

  always_ff @(posedge clock_i) begin
    if (accept) begin
      held_word_q <= icache_data_i;
    end
  end

endmodule

`default_nettype wire

//--- pip_decode.sv
`timescale 1ns/1ps
`default_nettype none

module pip_decode import pip_pkg::*; (
  input  if_id_t                 in_i,
  output logic      [REG_AW-1:0] rfile_rd_addr1_o,
  output logic      [REG_AW-1:0] rfile_rd_addr2_o,
  input  wire logic [XLEN-1:0]   rfile_rd_data1_i,
  input  wire logic [XLEN-1:0]   rfile_rd_data2_i,
  input  id_ex_t                 ex_stage_i,
  output id_ex_t                 out_o,
  output logic                   stall_o
);

  logic [5:0]        opcode;
  logic [5:0]        funct;
  logic [REG_AW-1:0] rs;
  logic [REG_AW-1:0] rt;
  logic [REG_AW-1:0] rd;
  logic              known;
  logic              uses_rt;
  logic              live;
  logic [REG_AW-1:0] dest;
  alu_op_t           alu_op;

  assign opcode = in_i.instr[31:26];
  assign rs     = in_i.instr[25:21];
  assign rt     = in_i.instr[20:16];
  assign rd     = in_i.instr[15:11];
  assign funct  = in_i.instr[5:0];

  assign rfile_rd_addr1_o = rs;
  assign rfile_rd_addr2_o = rt;

  always_comb begin
    known   = 1'b1;
    uses_rt = 1'b0;
    dest    = rt;
    alu_op  = ALU_ADD;
    case (opcode)
      OPC_RTYPE: begin
        uses_rt = 1'b1;
        dest    = rd;
        case (funct)
          FN_ADD:  alu_op = ALU_ADD;
          FN_SUB:  alu_op = ALU_SUB;
          FN_AND:  alu_op = ALU_AND;
          FN_OR:   alu_op = ALU_OR;
          FN_SLT:  alu_op = ALU_SLT;
          default: known = 1'b0;
        endcase
      end
      OPC_ADDI, OPC_LW: dest = rt;
      OPC_SW:           uses_rt = 1'b1;
      default:          known = 1'b0;
    endcase
  end

  // Load still in EX, its data is not there yet
  assign stall_o = in_i.valid & ex_stage_i.valid & ex_stage_i.load & ex_stage_i.dest_valid &
                   ((ex_stage_i.dest == rs) | (uses_rt & (ex_stage_i.dest == rt)));

  assign live = in_i.valid & ~stall_o;

  always_comb begin
    out_o            = '0;
    out_o.valid      = live;
    out_o.a_val      = rfile_rd_data1_i;
    out_o.b_val      = rfile_rd_data2_i;
    out_o.a_reg      = rs;
    out_o.b_reg      = rt;
    out_o.imm        = {{(XLEN-16){in_i.instr[15]}}, in_i.instr[15:0]};
    out_o.use_imm    = opcode != OPC_RTYPE;
    out_o.alu_op     = alu_op;
    out_o.load       = live & (opcode == OPC_LW);
    out_o.store      = live & (opcode == OPC_SW);
    out_o.dest       = dest;
    out_o.dest_valid = live & known & (opcode != OPC_SW) & (dest != '0);
  end

endmodule

`default_nettype wire

//--- pip_execute.sv
`timescale 1ns/1ps
`default_nettype none

module pip_execute import pip_pkg::*; (
  input  id_ex_t  in_i,
  input  ex_mem_t ex_mem_i,
  input  mem_wb_t mem_wb_i,
  output ex_mem_t out_o
);

  fwd_t            a_sel;
  fwd_t            b_sel;
  logic [XLEN-1:0] a_op;
  logic [XLEN-1:0] b_fwd;
  logic [XLEN-1:0] b_op;
  logic [XLEN-1:0] result;

  // Youngest producer wins
  function automatic fwd_t fwd_pick(input logic [REG_AW-1:0] src, input ex_mem_t em,
                                    input mem_wb_t mw);
    if (em.valid && em.dest_valid && em.dest == src) begin
      return FWD_EX_MEM;
    end else if (mw.valid && mw.dest_valid && mw.dest == src) begin
      return FWD_MEM_WB;
    end
    return FWD_NONE;
  endfunction

  function automatic logic [XLEN-1:0] fwd_mux(input fwd_t sel, input logic [XLEN-1:0] reg_val,
                                              input ex_mem_t em, input mem_wb_t mw);
    case (sel)
      FWD_EX_MEM: return em.result;
      FWD_MEM_WB: return mw.result;
      default:    return reg_val;
    endcase
  endfunction

  assign a_sel = fwd_pick(in_i.a_reg, ex_mem_i, mem_wb_i);
  assign b_sel = fwd_pick(in_i.b_reg, ex_mem_i, mem_wb_i);
  assign a_op  = fwd_mux(a_sel, in_i.a_val, ex_mem_i, mem_wb_i);
  assign b_fwd = fwd_mux(b_sel, in_i.b_val, ex_mem_i, mem_wb_i);
  assign b_op  = in_i.use_imm ? in_i.imm : b_fwd;

  // Loads and stores come in as ALU_ADD, giving base plus offset
  always_comb begin
    case (in_i.alu_op)
      ALU_SUB: result = a_op - b_op;
      ALU_AND: result = a_op & b_op;
      ALU_OR:  result = a_op | b_op;
      ALU_SLT: result = {{(XLEN-1){1'b0}}, $signed(a_op) < $signed(b_op)};
      default: result = a_op + b_op;
    endcase
  end

  assign out_o.valid      = in_i.valid;
  assign out_o.result     = result;
  assign out_o.store_data = b_fwd;
  assign out_o.load       = in_i.load;
  assign out_o.store      = in_i.store;
  assign out_o.dest       = in_i.dest;
  assign out_o.dest_valid = in_i.dest_valid;

endmodule

`default_nettype wire

//--- pip_memory.sv
`timescale 1ns/1ps
`default_nettype none

module pip_memory import pip_pkg::*; (
  input  ex_mem_t              in_i,
  output logic      [XLEN-1:0] dcache_addr_o,
  output logic                 dcache_rd_o,
  output logic                 dcache_wr_o,
  output logic      [XLEN-1:0] dcache_wr_data_o,
  output logic      [BE_W-1:0] dcache_wr_be_o,
  input  wire logic [XLEN-1:0] dcache_data_i,
  input  wire logic            dcache_waitrequest_i,
  output mem_wb_t              out_o,
  output logic                 stall_o
);

  logic access;

  assign access = in_i.valid & (in_i.load | in_i.store);

  // EX/MEM holds under stall, so the request stays stable
  assign dcache_addr_o    = in_i.result;
  assign dcache_rd_o      = in_i.valid & in_i.load;
  assign dcache_wr_o      = in_i.valid & in_i.store;
  assign dcache_wr_data_o = in_i.store_data;
  // Word accesses only
  assign dcache_wr_be_o   = {BE_W{1'b1}};

  assign stall_o = access & dcache_waitrequest_i;

  assign out_o.valid      = in_i.valid;
  assign out_o.result     = in_i.load ? dcache_data_i : in_i.result;
  assign out_o.dest       = in_i.dest;
  assign out_o.dest_valid = in_i.dest_valid;

endmodule

`default_nettype wire

//--- pip_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module pip_writeback import pip_pkg::*; (
  input  wire logic              clock_i,
  input  wire logic              rst_n_i,
  input  mem_wb_t                in_i,
  input  wire logic              hold_i,
  output logic      [REG_AW-1:0] rfile_wr_addr1_o,
  output logic                   rfile_wr_enable1_o,
  output logic      [XLEN-1:0]   rfile_wr_data1_o
);

  logic done_q;

  assign rfile_wr_enable1_o = in_i.valid & in_i.dest_valid & ~done_q;
  assign rfile_wr_addr1_o   = in_i.dest;
  assign rfile_wr_data1_o   = in_i.result;

  // Held MEM/WB entry is written once, on the first held cycle
  always_ff @(posedge clock_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      done_q <= 1'b0;
    end else begin
      done_q <= hold_i & (done_q | rfile_wr_enable1_o);
    end
  end

endmodule

`default_nettype wire

//--- pipeline.sv
`timescale 1ns/1ps
`default_nettype none

module pipeline import pip_pkg::*; (
  input  wire logic              clock_i,
  input  wire logic              rst_n_i,
  output logic      [XLEN-1:0]   icache_addr_o,
  output logic                   icache_rd_o,
  input  wire logic [XLEN-1:0]   icache_data_i,
  input  wire logic              icache_waitrequest_i,
  output logic      [REG_AW-1:0] rfile_rd_addr1_o,
  output logic      [REG_AW-1:0] rfile_rd_addr2_o,
  input  wire logic [XLEN-1:0]   rfile_rd_data1_i,
  input  wire logic [XLEN-1:0]   rfile_rd_data2_i,
  output logic      [XLEN-1:0]   dcache_addr_o,
  output logic                   dcache_rd_o,
  output logic                   dcache_wr_o,
  output logic      [XLEN-1:0]   dcache_wr_data_o,
  output logic      [BE_W-1:0]   dcache_wr_be_o,
  input  wire logic [XLEN-1:0]   dcache_data_i,
  input  wire logic              dcache_waitrequest_i,
  output logic      [REG_AW-1:0] rfile_wr_addr1_o,
  output logic                   rfile_wr_enable1_o,
  output logic      [XLEN-1:0]   rfile_wr_data1_o
);

  if_id_t  if_out;
  if_id_t  if_id_q;
  id_ex_t  id_out;
  id_ex_t  id_ex_q;
  ex_mem_t ex_out;
  ex_mem_t ex_mem_q;
  mem_wb_t mem_out;
  mem_wb_t mem_wb_q;
  logic    id_stall;
  logic    mem_stall;
  logic    front_hold;

  // Data cache stall freezes everything, load-use only the front end
  assign front_hold = mem_stall | id_stall;

  pip_fetch u_fetch (
    .clock_i              (clock_i),
    .rst_n_i              (rst_n_i),
    .stall_i              (front_hold),
    .icache_addr_o        (icache_addr_o),
    .icache_rd_o          (icache_rd_o),
    .icache_data_i        (icache_data_i),
    .icache_waitrequest_i (icache_waitrequest_i),
    .out_o                (if_out)
  );

  pip_stage_reg #(.payload_t(if_id_t)) u_if_id (
    .clock_i  (clock_i),
    .rst_n_i  (rst_n_i),
    .hold_i   (front_hold),
    .bubble_i (1'b0),
    .d_i      (if_out),
    .q_o      (if_id_q)
  );

  pip_decode u_decode (
    .in_i             (if_id_q),
    .rfile_rd_addr1_o (rfile_rd_addr1_o),
    .rfile_rd_addr2_o (rfile_rd_addr2_o),
    .rfile_rd_data1_i (rfile_rd_data1_i),
    .rfile_rd_data2_i (rfile_rd_data2_i),
    .ex_stage_i       (id_ex_q),
    .out_o            (id_out),
    .stall_o          (id_stall)
  );

  pip_stage_reg #(.payload_t(id_ex_t)) u_id_ex (
    .clock_i  (clock_i),
    .rst_n_i  (rst_n_i),
    .hold_i   (mem_stall),
    .bubble_i (id_stall),
    .d_i      (id_out),
    .q_o      (id_ex_q)
  );

  pip_execute u_execute (
    .in_i     (id_ex_q),
    .ex_mem_i (ex_mem_q),
    .mem_wb_i (mem_wb_q),
    .out_o    (ex_out)
  );

  pip_stage_reg #(.payload_t(ex_mem_t)) u_ex_mem (
    .clock_i  (clock_i),
    .rst_n_i  (rst_n_i),
    .hold_i   (mem_stall),
    .bubble_i (1'b0),
    .d_i      (ex_out),
    .q_o      (ex_mem_q)
  );

  pip_memory u_memory (
    .in_i                 (ex_mem_q),
    .dcache_addr_o        (dcache_addr_o),
    .dcache_rd_o          (dcache_rd_o),
    .dcache_wr_o          (dcache_wr_o),
    .dcache_wr_data_o     (dcache_wr_data_o),
    .dcache_wr_be_o       (dcache_wr_be_o),
    .dcache_data_i        (dcache_data_i),
    .dcache_waitrequest_i (dcache_waitrequest_i),
    .out_o                (mem_out),
    .stall_o              (mem_stall)
  );

  pip_stage_reg #(.payload_t(mem_wb_t)) u_mem_wb (
    .clock_i  (clock_i),
    .rst_n_i  (rst_n_i),
    .hold_i   (mem_stall),
    .bubble_i (1'b0),
    .d_i      (mem_out),
    .q_o      (mem_wb_q)
  );

  pip_writeback u_writeback (
    .clock_i            (clock_i),
    .rst_n_i            (rst_n_i),
    .in_i               (mem_wb_q),
    .hold_i             (mem_stall),
    .rfile_wr_addr1_o   (rfile_wr_addr1_o),
    .rfile_wr_enable1_o (rfile_wr_enable1_o),
    .rfile_wr_data1_o   (rfile_wr_data1_o)
  );

endmodule

`default_nettype wire

//--- pipeline_props.sv
`timescale 1ns/1ps
`default_nettype none

module pipeline_props import pip_pkg::*; (
  input wire logic              clock_i,
  input wire logic              rst_n_i,
  input wire logic [XLEN-1:0]   icache_addr_o,
  input wire logic              icache_rd_o,
  input wire logic              icache_waitrequest_i,
  input wire logic [XLEN-1:0]   dcache_addr_o,
  input wire logic              dcache_rd_o,
  input wire logic              dcache_wr_o,
  input wire logic [XLEN-1:0]   dcache_wr_data_o,
  input wire logic              dcache_waitrequest_i,
  input wire logic [REG_AW-1:0] rfile_wr_addr1_o,
  input wire logic              rfile_wr_enable1_o
);

  logic quiet;

  // No data access and no register write
  assign quiet = ~dcache_rd_o & ~dcache_wr_o & ~rfile_wr_enable1_o;

  // First instruction needs three cycles to reach MEM
  a_quiet_after_reset: assert property (@(posedge clock_i) disable iff (!rst_n_i)
    $rose(rst_n_i) |-> quiet ##1 quiet ##1 quiet)
    else $error("data access or register write right after reset");

  a_rd_wr_excl: assert property (@(posedge clock_i) disable iff (!rst_n_i)
    !(dcache_rd_o && dcache_wr_o))
    else $error("dcache read and write requested together");

  a_dcache_stable: assert property (@(posedge clock_i) disable iff (!rst_n_i)
    (dcache_waitrequest_i && (dcache_rd_o || dcache_wr_o)) |=>
      ($stable(dcache_addr_o) && $stable(dcache_wr_data_o) &&
       $stable(dcache_rd_o) && $stable(dcache_wr_o)))
    else $error("dcache request changed under waitrequest");

  a_icache_stable: assert property (@(posedge clock_i) disable iff (!rst_n_i)
    (icache_waitrequest_i && icache_rd_o) |=> (icache_rd_o && $stable(icache_addr_o)))
    else $error("icache request changed under waitrequest");

  a_no_r0_write: assert property (@(posedge clock_i) disable iff (!rst_n_i)
    rfile_wr_enable1_o |-> (rfile_wr_addr1_o != '0))
    else $error("register file write to r0");

endmodule

bind pipeline pipeline_props u_props (
  .clock_i              (clock_i),
  .rst_n_i              (rst_n_i),
  .icache_addr_o        (icache_addr_o),
  .icache_rd_o          (icache_rd_o),
  .icache_waitrequest_i (icache_waitrequest_i),
  .dcache_addr_o        (dcache_addr_o),
  .dcache_rd_o          (dcache_rd_o),
  .dcache_wr_o          (dcache_wr_o),
  .dcache_wr_data_o     (dcache_wr_data_o),
  .dcache_waitrequest_i (dcache_waitrequest_i),
  .rfile_wr_addr1_o     (rfile_wr_addr1_o),
  .rfile_wr_enable1_o   (rfile_wr_enable1_o)
);

`default_nettype wire

//--- tb_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pipeline import pip_pkg::*; ();

  localparam int PROG_LEN     = 64;
  localparam int PROG_AW      = 6;
  localparam int DRAM_WORDS   = 64;
  localparam int DRAM_AW      = 6;
  localparam int RESET_CYCLES = 8;
  localparam int TEST_CYCLES  = PROG_LEN * 8;
  localparam int DRAIN_CYCLES = 10;
  localparam int NUM_TESTS    = 2;
  localparam int WATCHDOG_NS  = NUM_TESTS * PROG_LEN * 20 * 8;
  localparam logic [XLEN-1:0] PROG_BYTES = XLEN'(PROG_LEN * 4);
  // Word stores enable every byte lane
  localparam logic [BE_W-1:0] WORD_BE = '1;

  logic              clock_i = 1'b0;
  logic              rst_n_i = 1'b0;
  logic [XLEN-1:0]   icache_addr_o;
  logic              icache_rd_o;
  logic [XLEN-1:0]   icache_data_i;
  logic              icache_waitrequest_i = 1'b0;
  logic [REG_AW-1:0] rfile_rd_addr1_o;
  logic [REG_AW-1:0] rfile_rd_addr2_o;
  logic [XLEN-1:0]   rfile_rd_data1_i;
  logic [XLEN-1:0]   rfile_rd_data2_i;
  logic [XLEN-1:0]   dcache_addr_o;
  logic              dcache_rd_o;
  logic              dcache_wr_o;
  logic [XLEN-1:0]   dcache_wr_data_o;
  logic [BE_W-1:0]   dcache_wr_be_o;
  logic [XLEN-1:0]   dcache_data_i;
  logic              dcache_waitrequest_i = 1'b0;
  logic [REG_AW-1:0] rfile_wr_addr1_o;
  logic              rfile_wr_enable1_o;
  logic [XLEN-1:0]   rfile_wr_data1_o;

  integer            seed = 32'haccc;
  logic              wait_en = 1'b0;
  logic [XLEN-1:0]   rom [PROG_LEN];
  logic [XLEN-1:0]   ram [DRAM_WORDS];
  logic [XLEN-1:0]   ram_model [DRAM_WORDS];
  logic [XLEN-1:0]   regs [32];
  logic [XLEN-1:0]   init_regs [32];
  logic [REG_AW-1:0] exp_wr_addr [$];
  logic [XLEN-1:0]   exp_wr_data [$];
  logic [XLEN-1:0]   exp_st_addr [$];
  logic [XLEN-1:0]   exp_st_data [$];
  int                wr_idx;
  int                st_idx;
  int                chk_err;
  int                pass_cnt;
  int                fail_cnt;

  always #4 clock_i = ~clock_i;

  pipeline u_pipeline (.*);

  // Cache models answer in the accepting cycle
  assign icache_data_i = (icache_addr_o < PROG_BYTES) ? rom[icache_addr_o[PROG_AW+1:2]] : '0;
  assign dcache_data_i = ram[dcache_addr_o[DRAM_AW+1:2]];

  // Write-through register file, r0 reads as zero
  assign rfile_rd_data1_i = (rfile_rd_addr1_o == '0) ? '0 :
      (rfile_wr_enable1_o && rfile_wr_addr1_o == rfile_rd_addr1_o) ? rfile_wr_data1_o :
      regs[rfile_rd_addr1_o];
  assign rfile_rd_data2_i = (rfile_rd_addr2_o == '0) ? '0 :
      (rfile_wr_enable1_o && rfile_wr_addr1_o == rfile_rd_addr2_o) ? rfile_wr_data1_o :
      regs[rfile_rd_addr2_o];

  // Register writes and accepted stores against the model, in order
  always @(posedge clock_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= init_regs[i];
      end
      for (int i = 0; i < DRAM_WORDS; i++) begin
        ram[i] <= '0;
      end
      wr_idx <= 0;
      st_idx <= 0;
    end else begin
      if (rfile_wr_enable1_o) begin
        if (wr_idx < exp_wr_addr.size()) begin
          assert (rfile_wr_addr1_o == exp_wr_addr[wr_idx]) else begin
            $display("mismatch rfile_wr_addr1_o: expected %h, got %h",
                     exp_wr_addr[wr_idx], rfile_wr_addr1_o);
            chk_err++;
          end
          assert (rfile_wr_data1_o == exp_wr_data[wr_idx]) else begin
            $display("mismatch rfile_wr_data1_o: expected %h, got %h",
                     exp_wr_data[wr_idx], rfile_wr_data1_o);
            chk_err++;
          end
        end else begin
          $display("register write to r%0d after the last expected write", rfile_wr_addr1_o);
          chk_err++;
        end
        wr_idx <= wr_idx + 1;
        if (rfile_wr_addr1_o != '0) begin
          regs[rfile_wr_addr1_o] <= rfile_wr_data1_o;
        end
      end
      if (dcache_wr_o && !dcache_waitrequest_i) begin
        if (st_idx < exp_st_addr.size()) begin
          assert (dcache_addr_o == exp_st_addr[st_idx]) else begin
            $display("mismatch dcache_addr_o: expected %h, got %h",
                     exp_st_addr[st_idx], dcache_addr_o);
            chk_err++;
          end
          assert (dcache_wr_data_o == exp_st_data[st_idx]) else begin
            $display("mismatch dcache_wr_data_o: expected %h, got %h",
                     exp_st_data[st_idx], dcache_wr_data_o);
            chk_err++;
          end
        end else begin
          $display("store to address %h after the last expected store", dcache_addr_o);
          chk_err++;
        end
        assert (dcache_wr_be_o == WORD_BE) else begin
          $display("mismatch dcache_wr_be_o: expected %h, got %h", WORD_BE, dcache_wr_be_o);
          chk_err++;
        end
        st_idx <= st_idx + 1;
        ram[dcache_addr_o[DRAM_AW+1:2]] <= dcache_wr_data_o;
      end
    end
  end

  function automatic logic [REG_AW-1:0] pick_reg();
    return REG_AW'(32'd1 + {$random(seed)} % 32'd7);
  endfunction

  function automatic logic [XLEN-1:0] rtype(input logic [5:0] fn);
    return {OPC_RTYPE, pick_reg(), pick_reg(), pick_reg(), 5'd0, fn};
  endfunction

  // Registers 1 to 7 only, so hazards come often
  task automatic make_program();
    logic [2:0]  kind;
    logic [15:0] offset;
    for (int i = 0; i < PROG_LEN; i++) begin
      kind   = 3'($random(seed));
      offset = 16'(({$random(seed)} % DRAM_WORDS) * 4);
      case (kind)
        3'd0:    rom[i] = rtype(FN_ADD);
        3'd1:    rom[i] = rtype(FN_SUB);
        3'd2:    rom[i] = rtype(FN_AND);
        3'd3:    rom[i] = rtype(FN_OR);
        3'd4:    rom[i] = rtype(FN_SLT);
        3'd5:    rom[i] = {OPC_ADDI, pick_reg(), pick_reg(), 16'($random(seed))};
        3'd6:    rom[i] = {OPC_LW, 5'd0, pick_reg(), offset};
        default: rom[i] = {OPC_SW, 5'd0, pick_reg(), offset};
      endcase
    end
  endtask

  // In-order interpreter for the expected writes, stores and final RAM
  task automatic run_model();
    logic [XLEN-1:0]   m [32];
    logic [XLEN-1:0]   instr;
    logic [XLEN-1:0]   a;
    logic [XLEN-1:0]   b;
    logic [XLEN-1:0]   imm;
    logic [XLEN-1:0]   addr;
    logic [XLEN-1:0]   res;
    logic [REG_AW-1:0] dst;
    logic              wr;
    for (int i = 0; i < 32; i++) begin
      m[i] = init_regs[i];
    end
    for (int i = 0; i < DRAM_WORDS; i++) begin
      ram_model[i] = '0;
    end
    for (int i = 0; i < PROG_LEN; i++) begin
      instr = rom[i];
      a     = m[instr[25:21]];
      b     = m[instr[20:16]];
      imm   = {{16{instr[15]}}, instr[15:0]};
      addr  = a + imm;
      dst   = instr[20:16];
      res   = '0;
      wr    = 1'b1;
      case (instr[31:26])
        OPC_RTYPE: begin
          dst = instr[15:11];
          case (instr[5:0])
            FN_ADD:  res = a + b;
            FN_SUB:  res = a - b;
            FN_AND:  res = a & b;
            FN_OR:   res = a | b;
            FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: wr = 1'b0;
          endcase
        end
        OPC_ADDI: res = a + imm;
        OPC_LW:   res = ram_model[addr[DRAM_AW+1:2]];
        OPC_SW: begin
          wr = 1'b0;
          exp_st_addr.push_back(addr);
          exp_st_data.push_back(b);
          ram_model[addr[DRAM_AW+1:2]] = b;
        end
        default: wr = 1'b0;
      endcase
      if (wr && dst != '0) begin
        m[dst] = res;
        exp_wr_addr.push_back(dst);
        exp_wr_data.push_back(res);
      end
    end
  endtask

  // One clock, with fresh waitrequest values for both ports
  task automatic step();
    @(posedge clock_i);
    icache_waitrequest_i <= wait_en & ({$random(seed)} % 32'd3 == 32'd0);
    dcache_waitrequest_i <= wait_en & ({$random(seed)} % 32'd3 == 32'd0);
  endtask

  task automatic run_test(input int num, input logic use_wait, input string name);
    int cycles;
    int err_start;
    int errs;
    err_start = chk_err;
    errs      = 0;
    cycles    = 0;
    wait_en   = use_wait;
    rst_n_i  <= 1'b0;
    repeat (RESET_CYCLES) step();
    rst_n_i  <= 1'b1;
    while ((wr_idx < exp_wr_addr.size() || st_idx < exp_st_addr.size()) &&
           cycles < TEST_CYCLES) begin
      step();
      cycles++;
    end
    if (wr_idx < exp_wr_addr.size() || st_idx < exp_st_addr.size()) begin
      $display("test %0d timed out after %0d of %0d writes and %0d of %0d stores", num,
               wr_idx, exp_wr_addr.size(), st_idx, exp_st_addr.size());
      errs++;
    end
    // Extra writes after the program would show up here
    repeat (DRAIN_CYCLES) step();
    for (int i = 0; i < DRAM_WORDS; i++) begin
      assert (ram[i] == ram_model[i]) else begin
        $display("mismatch ram[%0d]: expected %h, got %h", i, ram_model[i], ram[i]);
        errs++;
      end
    end
    errs = errs + chk_err - err_start;
    if (errs == 0) begin
      pass_cnt++;
    end else begin
      fail_cnt++;
    end
    $display("test %0d %s: %s, %0d errors", num, name, (errs == 0) ? "pass" : "fail", errs);
  endtask

  initial begin
    for (int i = 0; i < 32; i++) begin
      init_regs[i] = (i >= 1 && i <= 7) ? $random(seed) : '0;
    end
    make_program();
    run_model();
    run_test(0, 1'b0, "no waitrequest");
    run_test(1, 1'b1, "random waitrequest");
    $display("tests passed %0d, tests failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the tests finished");
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
pip_pkg.sv
pip_stage_reg.sv
pip_fetch.sv
pip_decode.sv
pip_execute.sv
pip_memory.sv
pip_writeback.sv
pipeline.sv
pipeline_props.sv
tb_pipeline.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -f sim.log
verilator --binary --assert -f list.f --top-module tb_pipeline -o tb_pipeline_sim
./obj_dir/tb_pipeline_sim > sim.log 2>&1 || true
cat sim.log
grep -q "TEST PASSED" sim.log
